// File: logic/sv39_pkg.sv
package sv39_pkg;

   localparam int VA_WIDTH = 64;
   localparam int PAGE_OFFSET_BITS = 12;
   localparam int VPN_BITS = 9;               // per level
   localparam int LEVELS = 3;
   localparam int PA_WIDTH = 32;
   localparam int PTE_BYTES_LG = 3;           // 8 byte entries
   localparam int PPN_BITS = 44;

   // leaf or pointer entry, flags in the low byte
   typedef struct packed {
      logic [9:0]          reserved;
      logic [PPN_BITS-1:0] ppn;
      logic [1:0]          rsw;               // left to software
      logic                dirty;
      logic                accessed;
      logic                global_page;
      logic                user;
      logic                execute;
      logic                write;
      logic                read;
      logic                valid;
   } pte_t;

   // also the walk level where the leaf was found
   typedef enum logic [1:0] {
      PG_1G = 2'd0,
      PG_2M = 2'd1,
      PG_4K = 2'd2
   } page_size_t;

endpackage

// File: logic/mmu_port_pkg.sv
package mmu_port_pkg;

   typedef enum logic {
      SIDE_I = 1'b0,
      SIDE_D = 1'b1
   } side_t;

   typedef struct packed {
      logic [sv39_pkg::VA_WIDTH-1:0] va;
      side_t                         side;
   } walk_req_t;

   typedef struct packed {
      logic [sv39_pkg::PA_WIDTH-1:0] paddr;
      logic                          fault;
      logic                          dirty;
      logic                          readable;
      logic                          writable;
      logic                          executable;
      logic                          user;
      sv39_pkg::page_size_t          pgsize;
   } xlate_rsp_t;

   // tag keeps the whole vpn, the cache compares the bits above its index
   typedef struct packed {
      logic                                                valid;
      logic [sv39_pkg::VA_WIDTH-sv39_pkg::PAGE_OFFSET_BITS-1:0] tag;
      xlate_rsp_t                                          rsp;
   } cache_entry_t;

endpackage

// File: logic/tlb_ram.sv
`timescale 1ns/1ps

module tlb_ram
#(
   parameter type entry_t = logic,
   parameter int LG_DEPTH = 8
)
(
   input  logic                clk,
   input  logic [LG_DEPTH-1:0] rd_addr,
   output entry_t              rd_data,
   input  logic                wr_en,
   input  logic [LG_DEPTH-1:0] wr_addr,
   input  entry_t              wr_data
);

   entry_t mem [0:(1 << LG_DEPTH)-1];

   always_ff @(posedge clk)
   begin
      rd_data <= mem[rd_addr];            // old data on same-address write
      if (wr_en)
      begin
         mem[wr_addr] <= wr_data;
      end
   end

endmodule

// File: logic/walk_request_arbiter.sv
`timescale 1ns/1ps

module walk_request_arbiter
(
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    l1i_req,
   input  logic                    l1d_req,
   input  logic [63:0]             l1i_va,
   input  logic [63:0]             l1d_va,
   input  logic                    busy,
   output logic                    start,
   output mmu_port_pkg::walk_req_t walk_req,
   output logic                    l1i_gnt,
   output logic                    l1d_gnt
);

   logic        i_pend;
   logic        d_pend;
   logic        want_i;
   logic        want_d;
   logic [63:0] i_va_hold;
   logic [63:0] d_va_hold;
   logic [63:0] i_va;
   logic [63:0] d_va;

   assign want_i = i_pend | l1i_req;
   assign want_d = d_pend | l1d_req;
   assign i_va = l1i_req ? l1i_va : i_va_hold;    // strobe cycle bypasses the hold
   assign d_va = l1d_req ? l1d_va : d_va_hold;

   assign start = ~busy & (want_i | want_d);
   assign walk_req.va = want_i ? i_va : d_va;      // iside first
   assign walk_req.side = want_i ? mmu_port_pkg::SIDE_I : mmu_port_pkg::SIDE_D;

   always_ff @(posedge clk)
   begin
      if (l1i_req)
      begin
         i_va_hold <= l1i_va;
      end
      if (l1d_req)
      begin
         d_va_hold <= l1d_va;
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         i_pend <= 1'b0;
         d_pend <= 1'b0;
         l1i_gnt <= 1'b0;
         l1d_gnt <= 1'b0;
      end
      else
      begin
         i_pend <= want_i & ~start;
         d_pend <= want_d & ~(start & ~want_i);
         l1i_gnt <= start & want_i;
         l1d_gnt <= start & ~want_i;
      end
   end

endmodule

// File: logic/translation_cache.sv
`timescale 1ns/1ps

module translation_cache
#(
   parameter int LG_TLB_SZ = 8
)
(
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     clear_tlb,
   input  logic                     lookup,
   input  logic [63:0]              lookup_va,
   output logic                     hit,
   output mmu_port_pkg::xlate_rsp_t hit_rsp,
   input  logic                     fill,
   input  logic [63:0]              fill_va,
   input  mmu_port_pkg::xlate_rsp_t fill_rsp
);

   localparam int VPN_W = sv39_pkg::VA_WIDTH - sv39_pkg::PAGE_OFFSET_BITS;
   localparam int TAG_W = VPN_W - LG_TLB_SZ;

   logic                       clr_active;
   logic [LG_TLB_SZ-1:0]       clr_cnt;
   logic [LG_TLB_SZ-1:0]       lookup_idx;
   logic [LG_TLB_SZ-1:0]       fill_idx;
   logic [TAG_W-1:0]           r_tag;
   logic                       valid_rd;
   mmu_port_pkg::cache_entry_t entry_rd;
   mmu_port_pkg::cache_entry_t entry_wr;

   assign lookup_idx = lookup_va[sv39_pkg::PAGE_OFFSET_BITS +: LG_TLB_SZ];
   assign fill_idx = fill_va[sv39_pkg::PAGE_OFFSET_BITS +: LG_TLB_SZ];

   // one entry per cycle, starts again on every clear
   always_ff @(posedge clk)
   begin
      if (reset | clear_tlb)
      begin
         clr_active <= 1'b1;
         clr_cnt <= '0;
      end
      else if (clr_active)
      begin
         clr_cnt <= clr_cnt + 1'b1;
         if (&clr_cnt)
         begin
            clr_active <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (lookup)
      begin
         r_tag <= lookup_va[sv39_pkg::VA_WIDTH-1 -: TAG_W];
      end
   end

   assign entry_wr.valid = 1'b1;
   assign entry_wr.tag = fill_va[sv39_pkg::VA_WIDTH-1:sv39_pkg::PAGE_OFFSET_BITS];
   assign entry_wr.rsp = fill_rsp;

   tlb_ram #(.entry_t(logic), .LG_DEPTH(LG_TLB_SZ)) valid_ram
   (
      .clk(clk),
      .rd_addr(lookup_idx),
      .rd_data(valid_rd),
      .wr_en(clr_active | fill),
      .wr_addr(clr_active ? clr_cnt : fill_idx),   // sweep wins
      .wr_data(~clr_active)
   );

   tlb_ram #(.entry_t(mmu_port_pkg::cache_entry_t), .LG_DEPTH(LG_TLB_SZ)) entry_ram
   (
      .clk(clk),
      .rd_addr(lookup_idx),
      .rd_data(entry_rd),
      .wr_en(fill),
      .wr_addr(fill_idx),
      .wr_data(entry_wr)
   );

   assign hit = ~clr_active & valid_rd & entry_rd.valid &
                (entry_rd.tag[VPN_W-1 -: TAG_W] == r_tag);
   assign hit_rsp = entry_rd.rsp;

endmodule

// File: logic/page_table_walker.sv
`timescale 1ns/1ps

module page_table_walker
(
   input  logic                          clk,
   input  logic                          reset,
   input  logic                          start,
   input  mmu_port_pkg::walk_req_t       walk_req,
   output logic                          busy,
   input  logic [63:0]                   page_table_root,
   input  logic                          hit,
   input  mmu_port_pkg::xlate_rsp_t      hit_rsp,
   output logic                          fill,
   output logic [63:0]                   fill_va,
   output mmu_port_pkg::xlate_rsp_t      fill_rsp,
   output logic                          mem_req_valid,
   output logic [sv39_pkg::PA_WIDTH-1:0] mem_req_addr,
   input  logic                          mem_rsp_valid,
   input  sv39_pkg::pte_t                mem_rsp_data,
   output logic                          mem_mark_valid,
   output logic [63:0]                   mem_mark_addr,
   input  logic                          mem_mark_rsp_valid,
   output mmu_port_pkg::xlate_rsp_t      xlate_rsp,
   output logic                          l1i_rsp_valid,
   output logic                          l1d_rsp_valid
);

   localparam int FULL_PA = sv39_pkg::PPN_BITS + sv39_pkg::PAGE_OFFSET_BITS;
   localparam int PO = sv39_pkg::PAGE_OFFSET_BITS;
   localparam int VB = sv39_pkg::VPN_BITS;

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_LOOKUP,
      ST_LOAD,
      ST_WAIT,
      ST_DONE,
      ST_MARK
   } state_t;

   state_t                        r_state, n_state;
   logic [63:0]                   r_va, n_va;
   mmu_port_pkg::side_t           r_side, n_side;
   sv39_pkg::page_size_t          r_level, n_level;
   sv39_pkg::pte_t                r_pte, n_pte;
   logic [sv39_pkg::PA_WIDTH-1:0] r_req_addr, n_req_addr;
   mmu_port_pkg::xlate_rsp_t      r_rsp, n_rsp;
   logic                          n_mem_req, n_mark, n_fill, respond;
   logic                          canonical;
   logic [VB-1:0]                 vpn;
   logic [FULL_PA-1:0]            table_base;
   logic [FULL_PA-1:0]            table_addr;
   logic [FULL_PA-1:0]            leaf_pa;

   // bits 63..38 must all match
   assign canonical = (&r_va[63:38]) | ~(|r_va[63:38]);
   assign vpn = r_va[PO + VB * (sv39_pkg::LEVELS - 1 - int'(r_level)) +: VB];
   assign table_base = (r_level == sv39_pkg::PG_1G) ? page_table_root[FULL_PA-1:0] :
                       {r_pte.ppn, {PO{1'b0}}};
   assign table_addr = table_base + FULL_PA'({vpn, {sv39_pkg::PTE_BYTES_LG{1'b0}}});

   always_comb
   begin
      case (r_level)
         sv39_pkg::PG_1G: leaf_pa = {r_pte.ppn[sv39_pkg::PPN_BITS-1:2*VB], r_va[PO +: 2*VB],
                                     {PO{1'b0}}};
         sv39_pkg::PG_2M: leaf_pa = {r_pte.ppn[sv39_pkg::PPN_BITS-1:VB], r_va[PO +: VB],
                                     {PO{1'b0}}};
         default:         leaf_pa = {r_pte.ppn, {PO{1'b0}}};
      endcase
   end

   always_comb
   begin
      n_state = r_state;
      n_va = r_va;
      n_side = r_side;
      n_level = r_level;
      n_pte = r_pte;
      n_req_addr = r_req_addr;
      n_rsp = r_rsp;
      n_mem_req = 1'b0;
      n_mark = 1'b0;
      n_fill = 1'b0;
      respond = 1'b0;
      case (r_state)
         ST_IDLE:
         begin
            if (start)
            begin
               n_va = walk_req.va;
               n_side = walk_req.side;
               n_level = sv39_pkg::PG_1G;
               n_state = ST_LOOKUP;
            end
         end
         ST_LOOKUP:
         begin
            if (~canonical)
            begin
               n_rsp = '0;
               n_rsp.fault = 1'b1;
               n_rsp.pgsize = r_level;
               respond = 1'b1;
               n_state = ST_IDLE;
            end
            else if (hit)
            begin
               n_rsp = hit_rsp;
               respond = 1'b1;
               n_state = ST_IDLE;
            end
            else
            begin
               n_state = ST_LOAD;
            end
         end
         ST_LOAD:
         begin
            n_req_addr = table_addr[sv39_pkg::PA_WIDTH-1:0];
            n_mem_req = 1'b1;
            n_state = ST_WAIT;
         end
         ST_WAIT:
         begin
            if (mem_rsp_valid)
            begin
               n_pte = mem_rsp_data;
               if (mem_rsp_data.read | mem_rsp_data.write | mem_rsp_data.execute)
               begin
                  n_state = mem_rsp_data.valid ? ST_DONE : ST_IDLE;
               end
               else if (mem_rsp_data.valid & (r_level != sv39_pkg::PG_4K))
               begin
                  n_level = sv39_pkg::page_size_t'(r_level + 2'd1);
                  n_state = ST_LOAD;
               end
               else
               begin
                  n_state = ST_IDLE;
               end
               if (n_state == ST_IDLE)            // invalid, or pointer at last level
               begin
                  n_rsp = '0;
                  n_rsp.fault = 1'b1;
                  n_rsp.pgsize = r_level;
                  respond = 1'b1;
               end
            end
         end
         ST_DONE:
         begin
            n_rsp.paddr = leaf_pa[sv39_pkg::PA_WIDTH-1:0];
            n_rsp.fault = 1'b0;
            n_rsp.dirty = r_pte.dirty;
            n_rsp.readable = r_pte.read;
            n_rsp.writable = r_pte.write;
            n_rsp.executable = r_pte.execute;
            n_rsp.user = r_pte.user;
            n_rsp.pgsize = r_level;
            respond = 1'b1;
            n_fill = (r_level == sv39_pkg::PG_4K);  // only 4k pages are cached
            n_mark = ~r_pte.accessed;
            n_state = r_pte.accessed ? ST_IDLE : ST_MARK;
         end
         ST_MARK:
         begin
            if (mem_mark_rsp_valid)
            begin
               n_state = ST_IDLE;
            end
         end
         default:
         begin
            n_state = ST_IDLE;
         end
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         r_state <= ST_IDLE;
         mem_req_valid <= 1'b0;
         mem_mark_valid <= 1'b0;
         fill <= 1'b0;
         l1i_rsp_valid <= 1'b0;
         l1d_rsp_valid <= 1'b0;
      end
      else
      begin
         r_state <= n_state;
         mem_req_valid <= n_mem_req;
         mem_mark_valid <= n_mark;
         fill <= n_fill;
         l1i_rsp_valid <= respond & (r_side == mmu_port_pkg::SIDE_I);
         l1d_rsp_valid <= respond & (r_side == mmu_port_pkg::SIDE_D);
      end
   end

   always_ff @(posedge clk)
   begin
      r_va <= n_va;
      r_side <= n_side;
      r_level <= n_level;
      r_pte <= n_pte;
      r_req_addr <= n_req_addr;
      r_rsp <= n_rsp;
   end

   assign busy = (r_state != ST_IDLE);
   assign mem_req_addr = r_req_addr;
   assign mem_mark_addr = 64'(r_req_addr);   // last read was the leaf
   assign xlate_rsp = r_rsp;
   assign fill_va = r_va;
   assign fill_rsp = r_rsp;

endmodule

// File: logic/mmu.sv
`timescale 1ns/1ps

module mmu
#(
   parameter int LG_TLB_SZ = 8
)
(
   input  logic                          clk,
   input  logic                          reset,
   input  logic                          clear_tlb,
   input  logic [63:0]                   page_table_root,
   input  logic                          l1i_req,
   input  logic [63:0]                   l1i_va,
   input  logic                          l1d_req,
   input  logic [63:0]                   l1d_va,
   output logic                          l1i_gnt,
   output logic                          l1d_gnt,
   output logic                          mem_req_valid,
   output logic [sv39_pkg::PA_WIDTH-1:0] mem_req_addr,
   input  logic                          mem_rsp_valid,
   input  sv39_pkg::pte_t                mem_rsp_data,
   output logic                          mem_mark_valid,
   output logic [63:0]                   mem_mark_addr,
   input  logic                          mem_mark_rsp_valid,
   output mmu_port_pkg::xlate_rsp_t      xlate_rsp,
   output logic                          l1i_rsp_valid,
   output logic                          l1d_rsp_valid
);

   logic                     start;
   logic                     busy;
   mmu_port_pkg::walk_req_t  walk_req;
   logic                     hit;
   mmu_port_pkg::xlate_rsp_t hit_rsp;
   logic                     fill;
   logic [63:0]              fill_va;
   mmu_port_pkg::xlate_rsp_t fill_rsp;

   walk_request_arbiter arbiter
   (
      .clk(clk),
      .reset(reset),
      .l1i_req(l1i_req),
      .l1d_req(l1d_req),
      .l1i_va(l1i_va),
      .l1d_va(l1d_va),
      .busy(busy),
      .start(start),
      .walk_req(walk_req),
      .l1i_gnt(l1i_gnt),
      .l1d_gnt(l1d_gnt)
   );

   translation_cache #(.LG_TLB_SZ(LG_TLB_SZ)) cache
   (
      .clk(clk),
      .reset(reset),
      .clear_tlb(clear_tlb),
      .lookup(start),
      .lookup_va(walk_req.va),
      .hit(hit),
      .hit_rsp(hit_rsp),
      .fill(fill),
      .fill_va(fill_va),
      .fill_rsp(fill_rsp)
   );

   page_table_walker walker
   (
      .clk(clk),
      .reset(reset),
      .start(start),
      .walk_req(walk_req),
      .busy(busy),
      .page_table_root(page_table_root),
      .hit(hit),
      .hit_rsp(hit_rsp),
      .fill(fill),
      .fill_va(fill_va),
      .fill_rsp(fill_rsp),
      .mem_req_valid(mem_req_valid),
      .mem_req_addr(mem_req_addr),
      .mem_rsp_valid(mem_rsp_valid),
      .mem_rsp_data(mem_rsp_data),
      .mem_mark_valid(mem_mark_valid),
      .mem_mark_addr(mem_mark_addr),
      .mem_mark_rsp_valid(mem_mark_rsp_valid),
      .xlate_rsp(xlate_rsp),
      .l1i_rsp_valid(l1i_rsp_valid),
      .l1d_rsp_valid(l1d_rsp_valid)
   );

endmodule

// File: tb/mmu_assertions.sv
`timescale 1ns/1ps

module mmu_assertions
(
   input logic clk,
   input logic reset,
   input logic l1i_gnt,
   input logic l1d_gnt,
   input logic l1i_rsp_valid,
   input logic l1d_rsp_valid,
   input logic mem_req_valid,
   input logic mem_mark_valid,
   input logic mem_mark_rsp_valid
);

   int   fails = 0;
   logic mark_open;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         mark_open <= 1'b0;
      end
      else if (mem_mark_valid)
      begin
         mark_open <= 1'b1;
      end
      else if (mem_mark_rsp_valid)
      begin
         mark_open <= 1'b0;
      end
   end

   grants_exclusive: assert property (@(posedge clk) disable iff (reset)
      !(l1i_gnt && l1d_gnt))
   else
   begin
      fails++;
      $error("l1i and l1d grants high together");
   end

   rsp_exclusive: assert property (@(posedge clk) disable iff (reset)
      !(l1i_rsp_valid && l1d_rsp_valid))
   else
   begin
      fails++;
      $error("both response strobes high together");
   end

   req_single_cycle: assert property (@(posedge clk) disable iff (reset)
      mem_req_valid |=> !mem_req_valid)
   else
   begin
      fails++;
      $error("mem_req_valid high in two consecutive cycles");
   end

   no_req_during_mark: assert property (@(posedge clk) disable iff (reset)
      mark_open |-> !mem_req_valid)
   else
   begin
      fails++;
      $error("memory read issued while a mark is outstanding");
   end

endmodule

bind mmu mmu_assertions checks
(
   .clk(clk),
   .reset(reset),
   .l1i_gnt(l1i_gnt),
   .l1d_gnt(l1d_gnt),
   .l1i_rsp_valid(l1i_rsp_valid),
   .l1d_rsp_valid(l1d_rsp_valid),
   .mem_req_valid(mem_req_valid),
   .mem_mark_valid(mem_mark_valid),
   .mem_mark_rsp_valid(mem_mark_rsp_valid)
);

// File: tb/mmu_tb.sv
`timescale 1ns/1ps

module mmu_tb;

   localparam int LG_TLB_SZ = 8;
   localparam int NUM_TESTS = 35;
   localparam logic [63:0] ROOT = 64'h0000_8000;

   logic                                clk = 1'b0;
   logic                                reset = 1'b1;
   logic                                clear_tlb = 1'b0;
   logic [63:0]                         page_table_root = ROOT;
   logic                                l1i_req = 1'b0;
   logic [63:0]                         l1i_va = '0;
   logic                                l1d_req = 1'b0;
   logic [63:0]                         l1d_va = '0;
   logic                                l1i_gnt;
   logic                                l1d_gnt;
   logic                                mem_req_valid;
   logic [sv39_pkg::PA_WIDTH-1:0]       mem_req_addr;
   logic                                mem_rsp_valid = 1'b0;
   sv39_pkg::pte_t                      mem_rsp_data = '0;
   logic                                mem_mark_valid;
   logic [63:0]                         mem_mark_addr;
   logic                                mem_mark_rsp_valid = 1'b0;
   mmu_port_pkg::xlate_rsp_t            xlate_rsp;
   logic                                l1i_rsp_valid;
   logic                                l1d_rsp_valid;

   logic [15:0]                         lfsr = 16'd61435;
   logic [63:0]                         pt_mem [logic [31:0]];
   logic [31:0]                         next_page = 32'h0010_0000;
   logic [31:0]                         exp_reads [$];
   logic [63:0]                         exp_marks [$];
   logic                                mem_busy = 1'b0;
   int                                  gnt_i_cnt = 0;
   int                                  gnt_d_cnt = 0;
   string                               cur_test = "reset";
   logic                                c_valid [0:(1 << LG_TLB_SZ)-1];
   logic [51:0]                         c_vpn [0:(1 << LG_TLB_SZ)-1];
   mmu_port_pkg::xlate_rsp_t            c_rsp [0:(1 << LG_TLB_SZ)-1];

   mmu #(.LG_TLB_SZ(LG_TLB_SZ)) dut
   (
      .clk(clk), .reset(reset), .clear_tlb(clear_tlb), .page_table_root(page_table_root),
      .l1i_req(l1i_req), .l1i_va(l1i_va), .l1d_req(l1d_req), .l1d_va(l1d_va),
      .l1i_gnt(l1i_gnt), .l1d_gnt(l1d_gnt),
      .mem_req_valid(mem_req_valid), .mem_req_addr(mem_req_addr),
      .mem_rsp_valid(mem_rsp_valid), .mem_rsp_data(mem_rsp_data),
      .mem_mark_valid(mem_mark_valid), .mem_mark_addr(mem_mark_addr),
      .mem_mark_rsp_valid(mem_mark_rsp_valid),
      .xlate_rsp(xlate_rsp), .l1i_rsp_valid(l1i_rsp_valid), .l1d_rsp_valid(l1d_rsp_valid)
   );

   always #20 clk = ~clk;

   // taps 16 14 13 11
   function automatic logic [63:0] lfsr_bits(input int n);
      logic [63:0] v;
      logic        fb;
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
         lfsr = {lfsr[14:0], fb};
         v = {v[62:0], fb};
      end
      return v;
   endfunction

   function automatic logic [63:0] read_mem(input logic [31:0] addr);
      return pt_mem.exists(addr) ? pt_mem[addr] : 64'h0;
   endfunction

   function automatic logic [63:0] rand_va();
      logic [63:0] v;
      v = lfsr_bits(39);
      v[63:39] = {25{v[38]}};                      // sign extend
      return v;
   endfunction

   task automatic stop_run();
      $display("tests failed");
      $fatal(1, "stopping at first error");
   endtask

   task automatic report_failure(input string msg);
      $display("%s (test %s)", msg, cur_test);
      stop_run();
   endtask

   task automatic check_rsp(input string name, input mmu_port_pkg::xlate_rsp_t exp,
                            input mmu_port_pkg::xlate_rsp_t act);
      if (act !== exp)
      begin
         $display("** Error %s: expected %h, actual %h", name, exp, act);
         stop_run();
      end
   endtask

   task automatic check_addr(input string name, input logic [63:0] exp,
                             input logic [63:0] act);
      if (act !== exp)
      begin
         $display("** Error %s: expected %h, actual %h", name, exp, act);
         stop_run();
      end
   endtask

   // leaf at leaf_lvl and no invalid entry when bad_lvl is -1
   task automatic build_map(input logic [63:0] va, input int leaf_lvl, input int bad_lvl);
      logic [63:0]    base;
      logic [31:0]    addr;
      sv39_pkg::pte_t pte;
      base = ROOT;
      for (int lvl = 0; lvl <= leaf_lvl; lvl++)
      begin
         addr = base[31:0] + {20'h0, va[12 + 9*(2-lvl) +: 9], 3'b000};
         pte = '0;
         pte.valid = 1'b1;
         if (lvl < leaf_lvl)
         begin
            pte.ppn = 44'(next_page >> 12);
            next_page += 32'h1000;
         end
         else
         begin
            pte.ppn = 44'(lfsr_bits(20));
            pte.read = 1'(lfsr_bits(1));
            pte.write = 1'(lfsr_bits(1));
            pte.execute = 1'(lfsr_bits(1));
            if (!(pte.read | pte.write | pte.execute))
            begin
               pte.read = 1'b1;
            end
            pte.user = 1'(lfsr_bits(1));
            pte.accessed = 1'(lfsr_bits(1));
            pte.dirty = 1'(lfsr_bits(1));
         end
         if (lvl == bad_lvl)
         begin
            pte.valid = 1'b0;
         end
         pt_mem[addr] = pte;
         base = 64'(pte.ppn) << 12;
         if (lvl == bad_lvl)
         begin
            break;
         end
      end
   endtask

   // reference walk that queues the expected reads and marks
   task automatic predict(input logic [63:0] va, output mmu_port_pkg::xlate_rsp_t rsp);
      logic [63:0]    base;
      logic [63:0]    pa;
      logic [31:0]    addr;
      sv39_pkg::pte_t pte;
      int             lvl;
      int             idx;
      logic           done;
      rsp = '0;
      idx = int'(va[12 +: LG_TLB_SZ]);
      if (va[63:38] != {26{va[38]}})
      begin
         rsp.fault = 1'b1;
         rsp.pgsize = sv39_pkg::PG_1G;
      end
      else if (c_valid[idx] && c_vpn[idx] == va[63:12])
      begin
         rsp = c_rsp[idx];
      end
      else
      begin
         base = ROOT;
         lvl = 0;
         done = 1'b0;
         while (!done)
         begin
            addr = base[31:0] + {20'h0, va[12 + 9*(2-lvl) +: 9], 3'b000};
            exp_reads.push_back(addr);
            pte = read_mem(addr);
            rsp.pgsize = sv39_pkg::page_size_t'(lvl);
            if (!pte.valid || (!(pte.read | pte.write | pte.execute) && lvl == 2))
            begin
               rsp.fault = 1'b1;
               done = 1'b1;
            end
            else if (pte.read | pte.write | pte.execute)
            begin
               pa = 64'(pte.ppn) << 12;
               if (lvl == 0)
               begin
                  pa = (pa & ~64'h3FFF_FFFF) | (va & 64'h3FFF_F000);
               end
               else if (lvl == 1)
               begin
                  pa = (pa & ~64'h1F_FFFF) | (va & 64'h1F_F000);
               end
               rsp.paddr = pa[31:0];
               rsp.dirty = pte.dirty;
               rsp.readable = pte.read;
               rsp.writable = pte.write;
               rsp.executable = pte.execute;
               rsp.user = pte.user;
               if (!pte.accessed)
               begin
                  exp_marks.push_back(64'(addr));
               end
               if (lvl == 2)
               begin
                  c_valid[idx] = 1'b1;
                  c_vpn[idx] = va[63:12];
                  c_rsp[idx] = rsp;
               end
               done = 1'b1;
            end
            else
            begin
               base = 64'(pte.ppn) << 12;
               lvl++;
            end
         end
      end
   endtask

   task automatic wait_rsp(input mmu_port_pkg::side_t side, output int cnt);
      cnt = 1;
      while (1)
      begin
         @(negedge clk);
         if (side == mmu_port_pkg::SIDE_I ? l1i_rsp_valid : l1d_rsp_valid)
         begin
            break;
         end
         if (side == mmu_port_pkg::SIDE_I ? l1d_rsp_valid : l1i_rsp_valid)
         begin
            report_failure("response strobe came on the wrong side");
         end
         cnt++;
      end
   endtask

   task automatic drain(input int want_i, input int want_d);
      @(negedge clk);
      while (exp_marks.size() != 0 || mem_busy)
      begin
         @(negedge clk);
      end
      repeat (2) @(negedge clk);
      if (exp_reads.size() != 0)
      begin
         report_failure("walk issued fewer memory reads than predicted");
      end
      if (gnt_i_cnt != want_i || gnt_d_cnt != want_d)
      begin
         report_failure("grant count does not match the requests");
      end
   endtask

   task automatic run_single(input string name, input logic [63:0] va);
      mmu_port_pkg::xlate_rsp_t exp;
      mmu_port_pkg::side_t      side;
      int                       cnt;
      logic                     quick;
      cur_test = name;
      gnt_i_cnt = 0;
      gnt_d_cnt = 0;
      side = mmu_port_pkg::side_t'(1'(lfsr_bits(1)));
      predict(va, exp);
      quick = (exp_reads.size() == 0);
      @(posedge clk);
      #1;
      l1i_req = (side == mmu_port_pkg::SIDE_I);
      l1d_req = (side == mmu_port_pkg::SIDE_D);
      l1i_va = va;
      l1d_va = va;
      @(posedge clk);
      #1;
      l1i_req = 1'b0;
      l1d_req = 1'b0;
      wait_rsp(side, cnt);
      check_rsp(name, exp, xlate_rsp);
      if (quick && cnt != 2)
      begin
         report_failure("response without a walk did not come 2 cycles after start");
      end
      drain(int'(side == mmu_port_pkg::SIDE_I), int'(side == mmu_port_pkg::SIDE_D));
   endtask

   task automatic run_pair(input string name, input logic [63:0] va_i, input logic [63:0] va_d);
      mmu_port_pkg::xlate_rsp_t exp_i;
      mmu_port_pkg::xlate_rsp_t exp_d;
      int                       cnt;
      cur_test = name;
      gnt_i_cnt = 0;
      gnt_d_cnt = 0;
      predict(va_i, exp_i);                      // l1i walks first
      predict(va_d, exp_d);
      @(posedge clk);
      #1;
      l1i_req = 1'b1;
      l1d_req = 1'b1;
      l1i_va = va_i;
      l1d_va = va_d;
      @(posedge clk);
      #1;
      l1i_req = 1'b0;
      l1d_req = 1'b0;
      wait_rsp(mmu_port_pkg::SIDE_I, cnt);
      check_rsp({name, " l1i"}, exp_i, xlate_rsp);
      wait_rsp(mmu_port_pkg::SIDE_D, cnt);
      check_rsp({name, " l1d"}, exp_d, xlate_rsp);
      drain(1, 1);
   endtask

   always @(negedge clk)
   begin
      gnt_i_cnt += int'(l1i_gnt);
      gnt_d_cnt += int'(l1d_gnt);
   end

   // page-table memory with random reply delay
   initial
   begin
      logic [63:0] data;
      forever
      begin
         @(negedge clk);
         if (mem_req_valid)
         begin
            mem_busy = 1'b1;
            if (exp_reads.size() == 0)
            begin
               report_failure("unexpected memory read");
            end
            check_addr({cur_test, " read address"}, 64'(exp_reads.pop_front()),
                       64'(mem_req_addr));
            data = read_mem(mem_req_addr);
            repeat (1 + lfsr_bits(3)) @(posedge clk);
            #1;
            mem_rsp_valid = 1'b1;
            mem_rsp_data = data;
            @(posedge clk);
            #1;
            mem_rsp_valid = 1'b0;
            mem_busy = 1'b0;
         end
         else if (mem_mark_valid)
         begin
            mem_busy = 1'b1;
            if (exp_marks.size() == 0)
            begin
               report_failure("unexpected accessed-bit mark request");
            end
            check_addr({cur_test, " mark address"}, exp_marks.pop_front(), mem_mark_addr);
            repeat (1 + lfsr_bits(3)) @(posedge clk);
            #1;
            mem_mark_rsp_valid = 1'b1;
            @(posedge clk);
            #1;
            mem_mark_rsp_valid = 1'b0;
            mem_busy = 1'b0;
         end
      end
   end

   initial
   begin
      #(64'(NUM_TESTS) * 2000 * 40);
      $display("watchdog expired, the DUT stopped responding during test %s", cur_test);
      $display("tests failed");
      $fatal(1, "timeout");
   end

   initial
   begin
      logic [63:0] va;
      logic [63:0] va_d;
      logic [63:0] last_4k;
      for (int i = 0; i < (1 << LG_TLB_SZ); i++)
      begin
         c_valid[i] = 1'b0;
      end
      repeat (5) @(posedge clk);
      #1;
      reset = 1'b0;
      repeat ((1 << LG_TLB_SZ) + 10) @(posedge clk);   // sweep after reset

      for (int t = 0; t < 8; t++)
      begin
         va = rand_va();
         build_map(va, 2, -1);
         run_single($sformatf("walk_4k_%0d", t), va);
         run_single($sformatf("hit_4k_%0d", t), va);
         last_4k = va;
      end
      for (int t = 0; t < 4; t++)
      begin
         va = rand_va();
         build_map(va, 1, -1);
         run_single($sformatf("page_2m_%0d", t), va);
         va = rand_va();
         build_map(va, 0, -1);
         run_single($sformatf("page_1g_%0d", t), va);
      end
      for (int t = 0; t < 2; t++)
      begin
         va = rand_va();
         va[63] = ~va[38];
         run_single($sformatf("non_canonical_%0d", t), va);
      end
      for (int t = 0; t < 4; t++)
      begin
         va = rand_va();
         build_map(va, 2, t % 3);
         run_single($sformatf("invalid_pte_%0d", t), va);
      end

      cur_test = "clear_tlb";
      @(posedge clk);
      #1;
      clear_tlb = 1'b1;
      @(posedge clk);
      #1;
      clear_tlb = 1'b0;
      repeat ((1 << LG_TLB_SZ) + 4) @(posedge clk);
      for (int i = 0; i < (1 << LG_TLB_SZ); i++)
      begin
         c_valid[i] = 1'b0;
      end
      run_single("walk_after_clear", last_4k);

      for (int t = 0; t < 4; t++)
      begin
         va = rand_va();
         build_map(va, 2, -1);
         va_d = rand_va();
         build_map(va_d, 2 - (t % 3), -1);
         run_pair($sformatf("arbitration_%0d", t), va, va_d);
      end

      repeat (4) @(posedge clk);
      if (dut.checks.fails != 0)
      begin
         $display("tests failed");
         $fatal(1, "assertion failures");
      end
      else
      begin
         $display("all tests passed");
         $finish;
      end
   end

endmodule

// File: list.f
logic/sv39_pkg.sv
logic/mmu_port_pkg.sv
logic/tlb_ram.sv
logic/walk_request_arbiter.sv
logic/translation_cache.sv
logic/page_table_walker.sv
logic/mmu.sv
tb/mmu_assertions.sv
tb/mmu_tb.sv

// File: Bender.yml
package:
  name: sv39_mmu

sources:
  - logic/sv39_pkg.sv
  - logic/mmu_port_pkg.sv
  - logic/tlb_ram.sv
  - logic/walk_request_arbiter.sv
  - logic/translation_cache.sv
  - logic/page_table_walker.sv
  - logic/mmu.sv
  - target: simulation
    files:
      - tb/mmu_assertions.sv
      - tb/mmu_tb.sv
